/* filelist.f */
src/lsq_pkg.sv
src/lane_capture.sv
src/same_bundle_check.sv
src/conflict_queue.sv
src/lsq_conflict_top.sv
tests/conflict_checker.sv
tests/tb_top.sv

/* run.sh */
#!/bin/sh
# build and run with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_top -f filelist.f > sim.log 2>&1 &&
  ./obj_dir/Vtb_top >> sim.log 2>&1 ||
  echo "** FAIL **" >> sim.log
cat sim.log
grep -qF "** FAIL **" sim.log && echo "simulation failed" && exit 1
echo "simulation passed"
exit 0

/* src/conflict_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module conflict_queue import lsq_pkg::*; (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      except,
  input  wire                      replay_stall,
  input  wire                      cap_valid,
  input  lane_mask_t               conflicts,
  input  lane_addr_t [LANES-1:0]   cap_addr,
  output logic                     take,
  output logic                     stall,
  output logic                     pick_valid,
  output lane_mask_t               pick_first,
  output lane_mask_t               pick_last,
  output lane_addr_t               pick_first_addr,
  output lane_addr_t               pick_last_addr,
  output logic       [CNT_W-1:0]   conf_cnt
);

  queue_state_e            state;
  lane_mask_t              pend;
  lane_mask_t              pend_next;
  lane_addr_t [LANES-1:0]  pend_addr;
  lane_mask_t              first_lane;
  lane_mask_t              last_lane;
  logic                    load;

  function automatic logic [CNT_W-1:0] popcount(input lane_mask_t m);
    logic [CNT_W-1:0] n;
    n = '0;
    for (int i = 0; i < LANES; i++) begin
      n = n + CNT_W'(m[i]);
    end
    return n;
  endfunction

  // isolate lowest set bit
  function automatic lane_mask_t lowest_bit(input lane_mask_t m);
    return m & (~m + LANES'(1));
  endfunction

  function automatic lane_mask_t highest_bit(input lane_mask_t m);
    lane_mask_t h;
    h = '0;
    for (int i = 0; i < LANES; i++) begin
      if (m[i]) begin
        h = lane_mask_t'(1) << i;
      end
    end
    return h;
  endfunction

  // one-hot select, zero when no lane chosen
  function automatic lane_addr_t sel_addr(input lane_mask_t onehot,
                                          input lane_addr_t [LANES-1:0] addrs);
    lane_addr_t a;
    a = '0;
    for (int i = 0; i < LANES; i++) begin
      if (onehot[i]) begin
        a = a | addrs[i];
      end
    end
    return a;
  endfunction

  assign conf_cnt = popcount(pend);

  // last is taken from what remains after first, so a single lane gives zero
  assign first_lane = lowest_bit(pend);
  assign last_lane  = highest_bit(pend & ~first_lane);

  // more than one pair left means the next bundle cannot load yet
  assign stall = replay_stall || (conf_cnt > CNT_W'(2));

  assign pick_valid = (state == Q_DRAIN) && !replay_stall;
  assign pick_first = pick_valid ? first_lane : '0;
  assign pick_last  = pick_valid ? last_lane : '0;

  assign pick_first_addr = sel_addr(pick_first, pend_addr);
  assign pick_last_addr  = sel_addr(pick_last, pend_addr);

  assign load = cap_valid && !stall;
  assign take = load;

  always_comb begin
    if (load) begin
      // old vector had at most two lanes and they go out on this edge
      pend_next = conflicts;
    end else if (pick_valid) begin
      pend_next = pend & ~pick_first & ~pick_last;
    end else begin
      pend_next = pend;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || except) begin
      pend  <= '0;
      state <= Q_IDLE;
    end else begin
      pend  <= pend_next;
      state <= (pend_next != '0) ? Q_DRAIN : Q_IDLE;
    end
  end

  // addresses follow the vector they belong to
  always_ff @(posedge clk) begin
    if (load) begin
      pend_addr <= cap_addr;
    end
  end

endmodule

`default_nettype wire

/* src/lane_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_capture import lsq_pkg::*; (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      except,
  input  wire                      bundle_valid,
  input  lane_mask_t               lane_en,
  input  lane_op_e   [LANES-1:0]   lane_op,
  input  lane_addr_t [LANES-1:0]   lane_addr,
  input  wire                      take,
  input  wire                      stall,
  output logic                     cap_valid,
  output lane_mask_t               cap_en,
  output lane_op_e   [LANES-1:0]   cap_op,
  output lane_addr_t [LANES-1:0]   cap_addr
);

  logic accept;

  // source must hold the bundle while stall is up
  assign accept = bundle_valid && !stall;

  // control part of the capture stage
  always_ff @(posedge clk) begin
    if (rst || except) begin
      // flush drops whatever sits in capture
      cap_valid <= 1'b0;
      cap_en    <= '0;
    end else if (accept) begin
      // a new bundle replaces the old one even on a take edge
      cap_valid <= 1'b1;
      cap_en    <= lane_en;
    end else if (take) begin
      cap_valid <= 1'b0;
      cap_en    <= '0;
    end
  end

  // lane payload, only meaningful with cap_valid
  always_ff @(posedge clk) begin
    if (accept) begin
      cap_op   <= lane_op;
      cap_addr <= lane_addr;
    end
  end

endmodule

`default_nettype wire

/* src/lsq_conflict_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_conflict_top import lsq_pkg::*; (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      bundle_valid,
  input  lane_mask_t               lane_en,
  input  lane_op_e   [LANES-1:0]   lane_op,
  input  lane_addr_t [LANES-1:0]   lane_addr,
  input  wire                      replay_stall,
  input  wire                      except,
  output logic                     stall,
  output logic                     pick_valid,
  output lane_mask_t               pick_first,
  output lane_mask_t               pick_last,
  output lane_addr_t               pick_first_addr,
  output lane_addr_t               pick_last_addr,
  output logic       [CNT_W-1:0]   conf_cnt
);

  logic                    cap_valid;
  lane_mask_t              cap_en;
  lane_op_e   [LANES-1:0]  cap_op;
  lane_addr_t [LANES-1:0]  cap_addr;
  lane_mask_t              conflicts;
  logic                    take;

  // bundle register
  lane_capture lane_capture_i (
    .clk          (clk),
    .rst          (rst),
    .except       (except),
    .bundle_valid (bundle_valid),
    .lane_en      (lane_en),
    .lane_op      (lane_op),
    .lane_addr    (lane_addr),
    .take         (take),
    .stall        (stall),
    .cap_valid    (cap_valid),
    .cap_en       (cap_en),
    .cap_op       (cap_op),
    .cap_addr     (cap_addr)
  );

  // store-to-lane address compare inside the bundle
  same_bundle_check same_bundle_check_i (
    .cap_valid (cap_valid),
    .cap_en    (cap_en),
    .cap_op    (cap_op),
    .cap_addr  (cap_addr),
    .conflicts (conflicts)
  );

  // pending lanes handed out two per cycle
  conflict_queue conflict_queue_i (
    .clk             (clk),
    .rst             (rst),
    .except          (except),
    .replay_stall    (replay_stall),
    .cap_valid       (cap_valid),
    .conflicts       (conflicts),
    .cap_addr        (cap_addr),
    .take            (take),
    .stall           (stall),
    .pick_valid      (pick_valid),
    .pick_first      (pick_first),
    .pick_last       (pick_last),
    .pick_first_addr (pick_first_addr),
    .pick_last_addr  (pick_last_addr),
    .conf_cnt        (conf_cnt)
  );

endmodule

`default_nettype wire

/* src/lsq_pkg.sv */
`default_nettype none

package lsq_pkg;

  // lanes in one load/store bundle
  localparam int LANES = 6;

  // lane address width
  localparam int ADDR_W = 12;

  // pending conflict count, holds 0..LANES
  localparam int CNT_W = 3;

  // lane operation
  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } lane_op_e;

  // conflict queue condition
  typedef enum logic {
    // nothing pending
    Q_IDLE  = 1'b0,
    // conflicting lanes still to hand out
    Q_DRAIN = 1'b1
  } queue_state_e;

  // one bit per lane
  typedef logic [LANES-1:0] lane_mask_t;

  // address of one lane
  typedef logic [ADDR_W-1:0] lane_addr_t;

endpackage

`default_nettype wire

/* src/same_bundle_check.sv */
`timescale 1ns/1ps
`default_nettype none

module same_bundle_check import lsq_pkg::*; (
  input  wire                      cap_valid,
  input  lane_mask_t               cap_en,
  input  lane_op_e   [LANES-1:0]   cap_op,
  input  lane_addr_t [LANES-1:0]   cap_addr,
  output lane_mask_t               conflicts
);

  // enabled store lanes of the captured bundle
  lane_mask_t store_en;

  // hit[t][j] set when store lane j lies below lane t and hits its address
  logic [LANES-1:0][LANES-1:0] hit;

  always_comb begin
    for (int j = 0; j < LANES; j++) begin
      store_en[j] = cap_en[j] && (cap_op[j] == OP_STORE);
    end
  end

  always_comb begin
    hit = '0;
    for (int t = 1; t < LANES; t++) begin
      // only lanes below t can be earlier in program order
      for (int j = 0; j < t; j++) begin
        hit[t][j] = store_en[j] && (cap_addr[j] == cap_addr[t]);
      end
    end
  end

  always_comb begin
    conflicts = '0;
    // lane 0 has nothing before it and stays clear
    for (int t = 1; t < LANES; t++) begin
      conflicts[t] = cap_valid && cap_en[t] && (|hit[t]);
    end
  end

endmodule

`default_nettype wire

/* tests/conflict_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module conflict_checker import lsq_pkg::*; (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      bundle_valid,
  input  lane_mask_t               lane_en,
  input  lane_op_e   [LANES-1:0]   lane_op,
  input  lane_addr_t [LANES-1:0]   lane_addr,
  input  wire                      replay_stall,
  input  wire                      except,
  input  wire                      stall,
  input  wire                      pick_valid,
  input  lane_mask_t               pick_first,
  input  lane_mask_t               pick_last,
  input  lane_addr_t               pick_first_addr,
  input  lane_addr_t               pick_last_addr,
  input  wire        [CNT_W-1:0]   conf_cnt,
  output int                       error_count,
  output int                       check_count,
  output int                       accept_count,
  output int                       pick_count,
  output logic                     busy
);

  // bundle held in the capture stage of the model
  logic                    cap_v;
  lane_mask_t              cap_conf;
  lane_addr_t [LANES-1:0]  cap_addr;
  // expected pick pairs, oldest first
  lane_mask_t              q_first[$];
  lane_mask_t              q_last[$];
  lane_addr_t              q_first_addr[$];
  lane_addr_t              q_last_addr[$];
  int                      pend_lanes;
  logic                    exp_stall;
  logic                    exp_pick;

  // lane t conflicts with an enabled store lane j below it at the same address
  function automatic lane_mask_t expected_conflicts(input lane_mask_t en,
                                                    input lane_op_e [LANES-1:0] op,
                                                    input lane_addr_t [LANES-1:0] addr);
    lane_mask_t m;
    m = '0;
    for (int t = 1; t < LANES; t++) begin
      for (int j = 0; j < t; j++) begin
        if (en[t] && en[j] && op[j] == OP_STORE && addr[j] == addr[t]) begin
          m[t] = 1'b1;
        end
      end
    end
    return m;
  endfunction

  // split a vector into lowest/highest pairs
  task automatic add_pairs(input lane_mask_t m, input lane_addr_t [LANES-1:0] addrs);
    int lo;
    int hi;
    while (m != '0) begin
      lo = LANES;
      hi = -1;
      for (int i = 0; i < LANES; i++) begin
        if (m[i] && lo == LANES) lo = i;
        if (m[i]) hi = i;
      end
      q_first.push_back(lane_mask_t'(1) << lo);
      q_first_addr.push_back(addrs[lo]);
      m[lo] = 1'b0;
      pend_lanes = pend_lanes + 1;
      if (hi != lo) begin
        q_last.push_back(lane_mask_t'(1) << hi);
        q_last_addr.push_back(addrs[hi]);
        m[hi] = 1'b0;
        pend_lanes = pend_lanes + 1;
      end else begin
        q_last.push_back('0);
        q_last_addr.push_back('0);
      end
    end
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count = check_count + 1;
    if (got !== exp) begin
      error_count = error_count + 1;
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      cap_v = 1'b0;
      q_first.delete();
      q_last.delete();
      q_first_addr.delete();
      q_last_addr.delete();
      pend_lanes = 0;
      error_count = 0;
      check_count = 0;
      accept_count = 0;
      pick_count = 0;
    end else begin
      exp_stall = replay_stall || (pend_lanes > 2);
      exp_pick  = (q_first.size() > 0) && !replay_stall;
      compare("stall", 32'(stall), 32'(exp_stall));
      compare("pick_valid", 32'(pick_valid), 32'(exp_pick));
      compare("conf_cnt", 32'(conf_cnt), 32'(pend_lanes));
      if (exp_pick) begin
        compare("pick_first", 32'(pick_first), 32'(q_first[0]));
        compare("pick_last", 32'(pick_last), 32'(q_last[0]));
        compare("pick_first_addr", 32'(pick_first_addr), 32'(q_first_addr[0]));
        if (q_last[0] != '0) begin
          compare("pick_last_addr", 32'(pick_last_addr), 32'(q_last_addr[0]));
        end
      end
      if (except) begin
        // flushed bundles never issue
        cap_v = 1'b0;
        q_first.delete();
        q_last.delete();
        q_first_addr.delete();
        q_last_addr.delete();
        pend_lanes = 0;
      end else begin
        if (exp_pick) begin
          pend_lanes = pend_lanes - ((q_last[0] != '0) ? 2 : 1);
          void'(q_first.pop_front());
          void'(q_last.pop_front());
          void'(q_first_addr.pop_front());
          void'(q_last_addr.pop_front());
          pick_count = pick_count + 1;
        end
        if (cap_v && !exp_stall) begin
          add_pairs(cap_conf, cap_addr);
          cap_v = 1'b0;
        end
        if (bundle_valid && !exp_stall) begin
          cap_v = 1'b1;
          cap_conf = expected_conflicts(lane_en, lane_op, lane_addr);
          cap_addr = lane_addr;
          accept_count = accept_count + 1;
        end
      end
    end
    busy = cap_v || (pend_lanes != 0);
  end

endmodule

`default_nettype wire

/* tests/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top import lsq_pkg::*; ();

  localparam int NUM_BUNDLES   = 64;
  localparam int TIMEOUT_CYCLES = (NUM_BUNDLES + 8) * 10 + 200;

  logic                    clk;
  logic                    rst;
  logic                    bundle_valid;
  lane_mask_t              lane_en;
  lane_op_e   [LANES-1:0]  lane_op;
  lane_addr_t [LANES-1:0]  lane_addr;
  logic                    replay_stall;
  logic                    except;
  logic                    stall;
  logic                    pick_valid;
  lane_mask_t              pick_first;
  lane_mask_t              pick_last;
  lane_addr_t              pick_first_addr;
  lane_addr_t              pick_last_addr;
  logic       [CNT_W-1:0]  conf_cnt;
  int                      error_count;
  int                      check_count;
  int                      accept_count;
  int                      pick_count;
  logic                    busy;
  logic       [31:0]       lfsr;
  logic                    quiet;

  lsq_conflict_top lsq_conflict_top_i (.*);

  conflict_checker conflict_checker_i (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = galois_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // replay_stall high about one cycle in four
  task automatic next_cycle(output logic stall_seen);
    logic [31:0] r;
    @(posedge clk);
    stall_seen = stall;
    @(negedge clk);
    take_bits(2, r);
    replay_stall = quiet ? 1'b0 : (r[1:0] == 2'b11);
  endtask

  // hold the bundle until an edge with stall low takes it
  task automatic send_bundle(input lane_mask_t en, input logic [LANES-1:0] ops,
                             input lane_addr_t [LANES-1:0] addrs);
    logic        stall_seen;
    logic [31:0] r;
    bundle_valid = 1'b1;
    lane_en = en;
    for (int i = 0; i < LANES; i++) lane_op[i] = lane_op_e'(ops[i]);
    lane_addr = addrs;
    stall_seen = 1'b1;
    while (stall_seen) next_cycle(stall_seen);
    bundle_valid = 1'b0;
    take_bits(1, r);
    if (r[0]) next_cycle(stall_seen);
  endtask

  task automatic random_bundle();
    logic [31:0]             r;
    logic [31:0]             hi;
    lane_mask_t              en;
    logic [LANES-1:0]        ops;
    lane_addr_t [LANES-1:0]  a;
    take_bits(6, r);
    en = r[5:0];
    take_bits(6, r);
    ops = r[5:0];
    // 2-bit address space per bundle keeps conflicts frequent
    take_bits(10, hi);
    for (int i = 0; i < LANES; i++) begin
      take_bits(2, r);
      a[i] = {hi[9:0], r[1:0]};
    end
    send_bundle(en, ops, a);
  endtask

  initial begin
    lane_addr_t [LANES-1:0] a;
    logic                   s;
    clk = 1'b0;
    rst = 1'b1;
    bundle_valid = 1'b0;
    lane_en = '0;
    for (int i = 0; i < LANES; i++) lane_op[i] = OP_LOAD;
    lane_addr = '0;
    replay_stall = 1'b0;
    except = 1'b0;
    quiet = 1'b0;
    lfsr = 32'hd98e_1dbc;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // loads only, then stores at distinct addresses
    for (int i = 0; i < LANES; i++) a[i] = 12'h0a4;
    send_bundle(6'b111111, 6'b000000, a);
    for (int i = 0; i < LANES; i++) a[i] = lane_addr_t'(12'h100 + i);
    send_bundle(6'b111111, 6'b111111, a);
    // five conflicts, then an odd three with lane 2 off
    for (int i = 0; i < LANES; i++) a[i] = 12'h2c8;
    send_bundle(6'b111111, 6'b111111, a);
    for (int i = 0; i < LANES; i++) a[i] = (i == 0) ? 12'h010 : 12'h355;
    send_bundle(6'b111011, 6'b000010, a);
    for (int b = 0; b < NUM_BUNDLES; b++) begin
      if (b == NUM_BUNDLES / 2) begin
        for (int i = 0; i < LANES; i++) a[i] = 12'h7e1;
        send_bundle(6'b111111, 6'b111111, a);
        except = 1'b1;
        next_cycle(s);
        except = 1'b0;
        repeat (3) next_cycle(s);
      end
      random_bundle();
    end
    quiet = 1'b1;
    replay_stall = 1'b0;
    while (busy) next_cycle(s);
    repeat (4) next_cycle(s);
    $display("checks %0d, errors %0d, bundles %0d, picks %0d",
             check_count, error_count, accept_count, pick_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire
